//--- tb/issue_golden.txt
# I class fn rs1 rs2 rd imm shamt pc expOpA expOpB flag (hex, flag 0 issue 1 stall 2 kill)
# W rd data, D idle cycles; class 0 reg 1 imm 2 shift 3 branch
I 0 0 01 00 03 00000000 00 00000100 00000000 00000000 0
W 01 00001111
W 02 a5a50002
I 0 8 01 02 00 00000000 00 00000104 00001111 a5a50002 0
I 1 0 01 05 04 fffff800 1f 00000108 00001111 fffff800 0
I 2 1 02 07 06 12345678 0c 0000010c a5a50002 0000000c 0
I 3 0 01 02 09 00000000 00 00000110 00001111 a5a50002 0
I 0 6 09 00 0a 00000000 00 00000114 00000000 00000000 0
I 0 7 04 01 0b 00000000 00 00000118 cafe0004 00001111 1
W 04 cafe0004
I 1 0 01 00 0c 00000010 00 0000011c 00001111 00000010 2
I 0 0 0c 01 0d 00000000 00 00000120 00000000 00001111 0
D 3
I 1 4 02 00 00 0000ffff 00 00000124 a5a50002 0000ffff 0
I 2 d 01 00 0e 00000000 05 00000128 00001111 00000005 0
I 0 3 02 04 00 00000000 00 0000012c a5a50002 cafe0004 0
W 0e 0000000e
I 0 2 0e 01 0f 00000000 00 00000130 0000000e 00001111 0
W 06 66666666
I 2 5 06 00 00 00000000 1f 00000134 66666666 0000001f 0

//--- sources.f
hdl/rvIsaPkg.sv
hdl/issuePkg.sv
hdl/issueBusIf.sv
hdl/regFile.sv
hdl/scoreboard.sv
hdl/issueCtrl.sv
hdl/flushTimer.sv
hdl/issueReg.sv
hdl/issueUnit.sv
tb/issueUnit_assertions.sv
tb/issueUnitTb.sv

//--- Bender.yml
package:
  name: issue_unit

sources:
  - hdl/rvIsaPkg.sv
  - hdl/issuePkg.sv
  - hdl/issueBusIf.sv
  - hdl/regFile.sv
  - hdl/scoreboard.sv
  - hdl/issueCtrl.sv
  - hdl/flushTimer.sv
  - hdl/issueReg.sv
  - hdl/issueUnit.sv
  - target: test
    files:
      - tb/issueUnit_assertions.sv
      - tb/issueUnitTb.sv

//--- tb/issueUnitTb.sv
`default_nettype none

module issueChecker import rvIsaPkg::*; (
	input logic clk,
	input logic nrst,
	input logic outValid,
	input logic outReady,
	input aluFnT outAluFn,
	input logic [REG_ADDR_W-1:0] outRd,
	input logic outWritesRd,
	input logic [XLEN-1:0] outOpA,
	input logic [XLEN-1:0] outOpB,
	input logic [XLEN-1:0] outPc
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		int unsigned id;
		aluFnT aluFn;
		logic [REG_ADDR_W-1:0] rd;
		logic writesRd;
		logic [XLEN-1:0] opA;
		logic [XLEN-1:0] opB;
		logic [XLEN-1:0] pc;
	} expT;

	// Expected instructions in issue order
	expT expQ[$];
	int errors = 0;
	int issued = 0;

	task automatic pushExpected(input int unsigned id, input aluFnT aluFn,
		input logic [REG_ADDR_W-1:0] rd, input logic writesRd,
		input logic [XLEN-1:0] opA, input logic [XLEN-1:0] opB,
		input logic [XLEN-1:0] pc);
		expQ.push_back('{id, aluFn, rd, writesRd, opA, opB, pc});
	endtask

	function automatic int pendingCount();
		return expQ.size();
	endfunction

	function automatic int compareField(string name, logic [XLEN-1:0] got,
		logic [XLEN-1:0] want);
		if (got !== want)
		begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
			return 1;
		end
		return 0;
	endfunction

	// Outputs settle by mid-cycle, the handshake completes at the next edge
	always @(negedge clk)
	begin : watch
		expT want;
		int bad;
		if (nrst && outValid && outReady)
		begin
			if (expQ.size() == 0)
			begin
				$display("Unexpected instruction issued at %0t with pc %h", $time, outPc);
				errors++;
			end
			else
			begin
				want = expQ.pop_front();
				bad = 0;
				bad += compareField("aluFn", XLEN'(outAluFn), XLEN'(want.aluFn));
				bad += compareField("rd", XLEN'(outRd), XLEN'(want.rd));
				bad += compareField("writesRd", XLEN'(outWritesRd), XLEN'(want.writesRd));
				bad += compareField("opA", outOpA, want.opA);
				bad += compareField("opB", outOpB, want.opB);
				bad += compareField("pc", outPc, want.pc);
				errors += bad;
				issued++;
				if (bad == 0)
					$display("Test %0d: pc %h issued as expected", want.id, want.pc);
				else
					$display("Test %0d: pc %h issued with %0d wrong fields", want.id, want.pc, bad);
			end
		end
	end

endmodule

module issueUnitTb import rvIsaPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 40;

	logic clk;
	logic nrst;
	logic inValid;
	logic inReady;
	opClassT inOpClass;
	aluFnT inAluFn;
	logic [REG_ADDR_W-1:0] inRs1;
	logic [REG_ADDR_W-1:0] inRs2;
	logic [REG_ADDR_W-1:0] inRd;
	logic [XLEN-1:0] inImm;
	logic [SHAMT_W-1:0] inShamt;
	logic [XLEN-1:0] inPc;
	logic wbEn;
	logic [REG_ADDR_W-1:0] wbRd;
	logic [XLEN-1:0] wbData;
	logic branchKill;
	logic outReady;
	logic outValid;
	aluFnT outAluFn;
	logic [REG_ADDR_W-1:0] outRd;
	logic outWritesRd;
	logic [XLEN-1:0] outOpA;
	logic [XLEN-1:0] outOpB;
	logic [XLEN-1:0] outPc;

	int testId = 0;
	int killed = 0;
	int drvErrors = 0;
	logic holding = 1'b0;
	logic aborted = 1'b0;

	issueUnit u_issueUnit (
		.clk(clk), .nrst(nrst), .inValid(inValid), .inReady(inReady),
		.inOpClass(inOpClass), .inAluFn(inAluFn), .inRs1(inRs1), .inRs2(inRs2),
		.inRd(inRd), .inImm(inImm), .inShamt(inShamt), .inPc(inPc),
		.wbEn(wbEn), .wbRd(wbRd), .wbData(wbData), .branchKill(branchKill),
		.outReady(outReady), .outValid(outValid), .outAluFn(outAluFn), .outRd(outRd),
		.outWritesRd(outWritesRd), .outOpA(outOpA), .outOpB(outOpB), .outPc(outPc)
	);

	issueChecker u_checker (
		.clk(clk), .nrst(nrst), .outValid(outValid), .outReady(outReady),
		.outAluFn(outAluFn), .outRd(outRd), .outWritesRd(outWritesRd),
		.outOpA(outOpA), .outOpB(outOpB), .outPc(outPc)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Random execute stalls, roughly one cycle in four
	initial
	begin
		void'($urandom(54));
		outReady = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			outReady = ($urandom % 4) != 0;
		end
	end

	// Holds inValid until inReady was seen before an edge
	task automatic waitAccept(input logic [XLEN-1:0] pc);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && !aborted)
		begin
			@(negedge clk);
			seen = inReady;
			@(posedge clk);
			#1;
			cycles++;
			if (!seen && cycles >= TIMEOUT_CYCLES)
			begin
				$display("Timeout: instruction at pc %h not accepted in %0d cycles", pc, cycles);
				aborted = 1'b1;
			end
		end
		inValid = 1'b0;
	endtask

	task automatic driveIssue(input logic [1:0] cls, input logic [3:0] fn,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
		input logic [31:0] imm, input logic [4:0] shamt, input logic [31:0] pc,
		input logic [31:0] expA, input logic [31:0] expB, input int flag);
		testId++;
		inOpClass = opClassT'(cls);
		inAluFn = aluFnT'(fn);
		inRs1 = rs1;
		inRs2 = rs2;
		inRd = rd;
		inImm = imm;
		inShamt = shamt;
		inPc = pc;
		inValid = 1'b1;
		// Branches, class 3, leave rd unwritten
		if (flag != 2)
			u_checker.pushExpected(testId, aluFnT'(fn), rd, cls != 2'd3, expA, expB, pc);
		if (flag == 1)
		begin
			// Source pending, must stay blocked until the writeback line
			for (int i = 0; i < 2 && inValid; i++)
			begin
				@(negedge clk);
				if (inReady)
				begin
					$display("Test %0d: pc %h accepted while its source was pending", testId, pc);
					drvErrors++;
				end
				@(posedge clk);
				#1;
				if (drvErrors != 0)
					inValid = 1'b0;
			end
			holding = inValid;
		end
		else
		begin
			waitAccept(pc);
			if (flag == 2 && !aborted)
			begin
				// Kill while it sits in the issue register
				branchKill = 1'b1;
				@(posedge clk);
				#1;
				branchKill = 1'b0;
				killed++;
				$display("Test %0d: pc %h killed in the issue register", testId, pc);
			end
		end
	endtask

	task automatic driveWb(input logic [4:0] rd, input logic [31:0] data);
		wbEn = 1'b1;
		wbRd = rd;
		wbData = data;
		@(posedge clk);
		#1;
		wbEn = 1'b0;
		// Stalled reader goes once the pending bit clears
		if (holding)
		begin
			holding = 1'b0;
			waitAccept(inPc);
		end
	endtask

	initial
	begin : driver
		int fd;
		int code;
		int cycles;
		int flag;
		int idle;
		string line;
		byte kind;
		logic [1:0] cls;
		logic [3:0] fn;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] expA;
		logic [31:0] expB;
		nrst = 1'b0;
		inValid = 1'b0;
		inOpClass = OP_REG;
		inAluFn = ADD;
		inRs1 = '0;
		inRs2 = '0;
		inRd = '0;
		inImm = '0;
		inShamt = '0;
		inPc = '0;
		wbEn = 1'b0;
		wbRd = '0;
		wbData = '0;
		branchKill = 1'b0;
		// Nothing offered and nothing taken while reset is held
		repeat (3)
		begin
			@(negedge clk);
			if (outValid !== 1'b0 || inReady !== 1'b0)
			begin
				$display("outValid or inReady was high during reset");
				drvErrors++;
			end
			@(posedge clk);
		end
		#1;
		nrst = 1'b1;
		fd = $fopen("tb/issue_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open tb/issue_golden.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code != 0)
			begin
				kind = line.getc(0);
				if (kind == "I")
				begin
					code = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %d",
						cls, fn, rs1, rs2, rd, imm, shamt, pc, expA, expB, flag);
					if (code == 11)
						driveIssue(cls, fn, rs1, rs2, rd, imm, shamt, pc, expA, expB, flag);
					else
						aborted = 1'b1;
				end
				else if (kind == "W")
				begin
					code = $sscanf(line, "W %h %h", rd, expA);
					if (code == 2)
						driveWb(rd, expA);
					else
						aborted = 1'b1;
				end
				else if (kind == "D")
				begin
					code = $sscanf(line, "D %d", idle);
					repeat (idle) @(posedge clk);
					#1;
				end
				if (aborted && code >= 0 && (kind == "I" || kind == "W"))
					$display("Golden line could not be parsed or timed out: %s", line);
			end
		end
		if (holding)
		begin
			$display("Golden file ended with an instruction still stalled");
			aborted = 1'b1;
		end
		cycles = 0;
		while (!aborted && u_checker.pendingCount() != 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
			begin
				$display("Timeout: %0d expected instructions never issued",
					u_checker.pendingCount());
				aborted = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("Summary: %0d tests, %0d issued, %0d killed, %0d errors", testId,
			u_checker.issued, killed, u_checker.errors + drvErrors);
		if (aborted || u_checker.errors != 0 || drvErrors != 0)
			$display("STATUS: FAIL");
		else
			$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/issueUnit_assertions.sv
`default_nettype none

module issueAssertions import rvIsaPkg::*, issuePkg::*; (
	input logic clk,
	input logic nrst,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic branchKill,
	input aluFnT outAluFn,
	input logic [REG_ADDR_W-1:0] outRd,
	input logic outWritesRd,
	input logic [XLEN-1:0] outOpA,
	input logic [XLEN-1:0] outOpB,
	input logic [XLEN-1:0] outPc,
	input ctrlStateT state
);
	timeunit 1ns;
	timeprecision 1ps;

	// Held instruction frozen while execute stalls, a kill may still remove it
	holdStable: assert property (@(posedge clk) disable iff (!nrst || branchKill)
		(outValid && !outReady) |=> (outValid && $stable(outAluFn) && $stable(outRd) &&
		$stable(outWritesRd) && $stable(outOpA) && $stable(outOpB) && $stable(outPc)))
		else $error("Issue register changed under back-pressure");

	// Kill opens a window of FLUSH_CYCLES cycles without accept
	flushBlocks: assert property (@(posedge clk) disable iff (!nrst)
		(branchKill && (state != FLUSH)) |=>
		((state == FLUSH) && !inReady) [*FLUSH_CYCLES] ##1 (state == EMPTY))
		else $error("Flush window has the wrong length or inReady was high during flush");

	// Nothing offered to execute in or right out of reset
	resetQuiet: assert property (@(posedge clk)
		(!nrst || $rose(nrst)) |-> !outValid)
		else $error("outValid high after reset");

endmodule

bind issueUnit issueAssertions u_issueAssertions (
	.clk(clk),
	.nrst(nrst),
	.inReady(inReady),
	.outValid(outValid),
	.outReady(outReady),
	.branchKill(branchKill),
	.outAluFn(outAluFn),
	.outRd(outRd),
	.outWritesRd(outWritesRd),
	.outOpA(outOpA),
	.outOpB(outOpB),
	.outPc(outPc),
	.state(u_issueCtrl.state)
);

`default_nettype wire

//--- hdl/issueUnit.sv
`default_nettype none

module issueUnit import rvIsaPkg::*; (
	input logic clk,
	input logic nrst,
	// From decode
	input logic inValid,
	output logic inReady,
	input opClassT inOpClass,
	input aluFnT inAluFn,
	input logic [REG_ADDR_W-1:0] inRs1,
	input logic [REG_ADDR_W-1:0] inRs2,
	input logic [REG_ADDR_W-1:0] inRd,
	input logic [XLEN-1:0] inImm,
	input logic [SHAMT_W-1:0] inShamt,
	input logic [XLEN-1:0] inPc,
	// From commit
	input logic wbEn,
	input logic [REG_ADDR_W-1:0] wbRd,
	input logic [XLEN-1:0] wbData,
	// From execute
	input logic branchKill,
	input logic outReady,
	// To execute
	output logic outValid,
	output aluFnT outAluFn,
	output logic [REG_ADDR_W-1:0] outRd,
	output logic outWritesRd,
	output logic [XLEN-1:0] outOpA,
	output logic [XLEN-1:0] outOpB,
	output logic [XLEN-1:0] outPc
);

	logic [XLEN-1:0] rdDataA;
	logic [XLEN-1:0] rdDataB;
	logic hazard;
	logic accept;
	logic load;
	logic drop;
	logic flushStart;
	logic flushDone;
	logic full;

	issueBusIf busIf ();

	regFile u_regFile (
		.clk(clk),
		.nrst(nrst),
		.wrEn(wbEn),
		.wrAddr(wbRd),
		.wrData(wbData),
		.rdAddrA(inRs1),
		.rdAddrB(inRs2),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	scoreboard u_scoreboard (
		.clk(clk),
		.nrst(nrst),
		.accept(accept),
		.inOpClass(inOpClass),
		.inRs1(inRs1),
		.inRs2(inRs2),
		.inRd(inRd),
		.wbEn(wbEn),
		.wbRd(wbRd),
		.drop(drop),
		.bus(busIf.monitor),
		.hazard(hazard)
	);

	issueCtrl u_issueCtrl (
		.clk(clk),
		.nrst(nrst),
		.inValid(inValid),
		.hazard(hazard),
		.branchKill(branchKill),
		.flushDone(flushDone),
		.bus(busIf.monitor),
		.inReady(inReady),
		.accept(accept),
		.load(load),
		.drop(drop),
		.flushStart(flushStart),
		.full(full)
	);

	flushTimer u_flushTimer (
		.clk(clk),
		.nrst(nrst),
		.start(flushStart),
		.done(flushDone)
	);

	issueReg u_issueReg (
		.clk(clk),
		.nrst(nrst),
		.load(load),
		.full(full),
		.inOpClass(inOpClass),
		.inAluFn(inAluFn),
		.inRd(inRd),
		.inImm(inImm),
		.inShamt(inShamt),
		.inPc(inPc),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.bus(busIf.source)
	);

	// Execute side of the bus
	assign busIf.ready = outReady;
	assign outValid = busIf.valid;
	assign outAluFn = busIf.aluFn;
	assign outRd = busIf.rd;
	assign outWritesRd = busIf.writesRd;
	assign outOpA = busIf.opA;
	assign outOpB = busIf.opB;
	assign outPc = busIf.pc;

endmodule

`default_nettype wire

//--- hdl/issueReg.sv
`default_nettype none

module issueReg import rvIsaPkg::*; (
	input logic clk,
	input logic nrst,
	input logic load,
	input logic full,
	// Fields from decode
	input opClassT inOpClass,
	input aluFnT inAluFn,
	input logic [REG_ADDR_W-1:0] inRd,
	input logic [XLEN-1:0] inImm,
	input logic [SHAMT_W-1:0] inShamt,
	input logic [XLEN-1:0] inPc,
	// Register file read data
	input logic [XLEN-1:0] rdDataA,
	input logic [XLEN-1:0] rdDataB,
	issueBusIf.source bus
);

	logic [XLEN-1:0] opBSel;

	// Operand B source by class
	always_comb
	begin
		unique case (inOpClass)
			OP_REG:    opBSel = rdDataB;
			OP_IMM:    opBSel = inImm;
			// Shift amount zero-extended
			OP_SHIFT:  opBSel = {{(XLEN - SHAMT_W){1'b0}}, inShamt};
			OP_BRANCH: opBSel = rdDataB;
			default:   opBSel = rdDataB;
		endcase
	end

	// Control fields
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			bus.aluFn <= ADD;
			bus.rd <= '0;
			bus.writesRd <= 1'b0;
		end
		else if (load)
		begin
			bus.aluFn <= inAluFn;
			bus.rd <= inRd;
			bus.writesRd <= classWritesRd(inOpClass);
		end
	end

	// Operands and pc, held while not loading
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			bus.opA <= rdDataA;
			bus.opB <= opBSel;
			bus.pc <= inPc;
		end
	end

	assign bus.valid = full;

endmodule

`default_nettype wire

//--- hdl/flushTimer.sv
`default_nettype none

module flushTimer import issuePkg::*; (
	input logic clk,
	input logic nrst,
	input logic start,
	output logic done
);

	// Cycles left in the window, zero when idle
	logic [FLUSH_CNT_W-1:0] count;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			count <= '0;
		else if (start)
			count <= FLUSH_CNT_W'(FLUSH_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// High in the last cycle of the window
	assign done = (count == FLUSH_CNT_W'(1));

endmodule

`default_nettype wire

//--- hdl/issueCtrl.sv
`default_nettype none

module issueCtrl import issuePkg::*; (
	input logic clk,
	input logic nrst,
	input logic inValid,
	input logic hazard,
	input logic branchKill,
	input logic flushDone,
	issueBusIf.monitor bus,
	output logic inReady,
	output logic accept,
	output logic load,
	output logic drop,
	output logic flushStart,
	output logic full
);

	ctrlStateT state;
	ctrlStateT nextState;
	logic issue;

	// Kill hides the held instruction at once, so it never handshakes
	assign full = (state == FULL) && !branchKill;
	assign issue = bus.valid && bus.ready;

	// Room exists when empty or when the slot frees this cycle
	// Closed while reset is held
	assign inReady = nrst && (state != FLUSH) && !branchKill && !hazard &&
		((state == EMPTY) || issue);
	assign accept = inValid && inReady;
	// Issue register loads exactly on an accepted instruction
	assign load = accept;

	assign drop = branchKill && (state == FULL);
	// Kill with nothing held still opens the window,
	// the instruction at the input is on the wrong path too
	assign flushStart = branchKill && (state != FLUSH);

	always_comb
	begin
		nextState = state;
		unique case (state)
			EMPTY:
				if (branchKill)
					nextState = FLUSH;
				else if (accept)
					nextState = FULL;
			FULL:
				if (branchKill)
					nextState = FLUSH;
				else if (issue && !accept)
					nextState = EMPTY;
			FLUSH:
				if (flushDone)
					nextState = EMPTY;
			default:
				nextState = EMPTY;
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			state <= EMPTY;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

//--- hdl/scoreboard.sv
`default_nettype none

module scoreboard import rvIsaPkg::*, issuePkg::*; (
	input logic clk,
	input logic nrst,
	// Instruction at the input handshake
	input logic accept,
	input opClassT inOpClass,
	input logic [REG_ADDR_W-1:0] inRs1,
	input logic [REG_ADDR_W-1:0] inRs2,
	input logic [REG_ADDR_W-1:0] inRd,
	// Writeback from commit
	input logic wbEn,
	input logic [REG_ADDR_W-1:0] wbRd,
	// Held instruction killed
	input logic drop,
	issueBusIf.monitor bus,
	output logic hazard
);

	// One bit per register, set while a writer is in flight
	logic [NUM_REGS-1:0] pending;
	logic [NUM_REGS-1:0] setVec;
	logic [NUM_REGS-1:0] clrVec;
	logic rs1Busy;
	logic rs2Busy;

	always_comb
	begin
		setVec = '0;
		clrVec = '0;
		// New writer, x0 never becomes pending
		if (accept && classWritesRd(inOpClass) && (inRd != '0))
			setVec[inRd] = 1'b1;
		if (wbEn)
			clrVec[wbRd] = 1'b1;
		// Killed writer will never write back
		if (drop && bus.writesRd)
			clrVec[bus.rd] = 1'b1;
	end

	// Set wins over clear on the same register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			pending <= '0;
		else
			pending <= (pending & ~clrVec) | setVec;
	end

	// RAW check on the sources this class actually reads
	assign rs1Busy = (inRs1 != '0) && pending[inRs1];
	assign rs2Busy = classReadsRs2(inOpClass) && (inRs2 != '0) && pending[inRs2];
	assign hazard = rs1Busy || rs2Busy;

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`default_nettype none

module regFile import rvIsaPkg::*, issuePkg::*; (
	input logic clk,
	input logic nrst,
	// Write port from commit
	input logic wrEn,
	input logic [REG_ADDR_W-1:0] wrAddr,
	input logic [XLEN-1:0] wrData,
	// Read ports for rs1 and rs2
	input logic [REG_ADDR_W-1:0] rdAddrA,
	input logic [REG_ADDR_W-1:0] rdAddrB,
	output logic [XLEN-1:0] rdDataA,
	output logic [XLEN-1:0] rdDataB
);

	logic [XLEN-1:0] regs [NUM_REGS];

	// Write at the rising edge
	// Entry 0 is never written so it stays zero
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn && (wrAddr != '0))
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Zero-latency reads
	// No same-cycle bypass, a write is visible from the next cycle
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

//--- hdl/issueBusIf.sv
`default_nettype none

// Issue register toward execute
interface issueBusIf import rvIsaPkg::*; ();

	// Handshake
	logic valid;
	logic ready;

	// Payload
	aluFnT aluFn;
	logic [REG_ADDR_W-1:0] rd;
	logic writesRd;
	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] pc;

	// Issue register side
	modport source (output valid, aluFn, rd, writesRd, opA, opB, pc, input ready);
	// Execute side
	modport sink (input valid, aluFn, rd, writesRd, opA, opB, pc, output ready);
	// Observers only
	modport monitor (input valid, ready, aluFn, rd, writesRd, opA, opB, pc);

endinterface

`default_nettype wire

//--- hdl/issuePkg.sv
`default_nettype none

package issuePkg;

	// Issue control states
	// EMPTY waits for an instruction, FULL holds one for execute,
	// FLUSH blocks issue after a branch kill
	typedef enum logic [1:0] {
		EMPTY = 2'b00,
		FULL  = 2'b01,
		FLUSH = 2'b10
	} ctrlStateT;

	// Length of the flush window in cycles
	localparam int FLUSH_CYCLES = 2;

	// Counter width, enough to hold FLUSH_CYCLES itself
	localparam int FLUSH_CNT_W = $clog2(FLUSH_CYCLES + 1);

	// Architectural registers
	localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

//--- hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	// Data path width of RV32I
	localparam int XLEN = 32;
	// Five bits address x0..x31
	localparam int REG_ADDR_W = 5;
	// Shift amount field of RV32 shift-immediates
	localparam int SHAMT_W = 5;

	// Operand class from decode
	// Selects the source of operand B and whether rd is written
	typedef enum logic [1:0] {
		OP_REG    = 2'b00,
		OP_IMM    = 2'b01,
		OP_SHIFT  = 2'b10,
		OP_BRANCH = 2'b11
	} opClassT;

	// ALU function, encoded as {funct7[5], funct3}
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b1000,
		SLL  = 4'b0001,
		SLT  = 4'b0010,
		SLTU = 4'b0011,
		XOR  = 4'b0100,
		SRL  = 4'b0101,
		SRA  = 4'b1101,
		OR   = 4'b0110,
		AND  = 4'b0111
	} aluFnT;

	// Every class except branches produces a result for rd
	function automatic logic classWritesRd(opClassT opClass);
		return opClass != OP_BRANCH;
	endfunction

	// Only register-register ops and branches read rs2
	function automatic logic classReadsRs2(opClassT opClass);
		return (opClass == OP_REG) || (opClass == OP_BRANCH);
	endfunction

endpackage

`default_nettype wire
